/* hw/frogger_pkg.sv */
// frogger package with grid, pixel, colour, lane seed and step timing constants and types
package frogger_pkg;

    typedef logic [3:0]  col_t;
    typedef logic [2:0]  row_t;
    typedef logic [1:0]  lane_t;
    typedef logic [7:0]  px_x_t;
    typedef logic [6:0]  px_y_t;
    typedef logic [2:0]  colour_t;
    typedef logic [1:0]  speed_t;
    typedef logic [15:0] lane_bits_t;

    // playing field
    localparam int GRID_COLS = 16;
    localparam int GRID_ROWS = 7;
    localparam int LANE_COUNT = 4;
    // lane k sits on row k + 1
    localparam int FIRST_LANE_ROW = 1;

    // cell origin is col * 10, row * 15
    localparam int CELL_PITCH_X = 10;
    localparam int CELL_PITCH_Y = 15;
    localparam int BLOCK_SIDE = 8;
    localparam int BLOCK_PIXELS = BLOCK_SIDE * BLOCK_SIDE;
    localparam int SIDE_BITS = $clog2(BLOCK_SIDE);

    localparam col_t FROG_START_COL = 4'd8;
    localparam row_t FROG_START_ROW = 3'd6;
    localparam row_t WIN_ROW = 3'd0;

    localparam colour_t COLOUR_FROG = 3'd7;
    localparam colour_t COLOUR_CAR = 3'd6;
    // road colour doubles as the erase colour
    localparam colour_t COLOUR_ROAD = 3'd0;

    // reset patterns, column c reads bit 15 - c
    localparam lane_bits_t LANE_SEED [LANE_COUNT] = '{
        16'b1000_1101_1000_0000,
        16'b1100_0011_0001_0011,
        16'b0011_0111_0001_1001,
        16'b0110_0011_1001_1100
    };

    // base step period in fastclock cycles
    localparam int unsigned DEFAULT_STEP_TICKS = 25_000_000;
    // wide enough for the slowest speed at the default period
    localparam int STEP_CNT_W = $clog2(4 * DEFAULT_STEP_TICKS);

endpackage

/* hw/lane_tick_timer.sv */
// lane_tick_timer: traffic step pulse generator with selectable period
`timescale 1ns/1ps

module lane_tick_timer #(
    parameter int unsigned STEP_TICKS = frogger_pkg::DEFAULT_STEP_TICKS
) (
    input  logic                fastclock,
    input  logic                resetn,
    input  frogger_pkg::speed_t speed_sel,
    output logic                step
);
    import frogger_pkg::*;

    logic [STEP_CNT_W-1:0] count;
    logic [STEP_CNT_W-1:0] reload;

    // 01 one base period, 10 two, 11 four
    always_comb begin
        case (speed_sel)
            2'b10:   reload = STEP_CNT_W'(2 * STEP_TICKS - 1);
            2'b11:   reload = STEP_CNT_W'(4 * STEP_TICKS - 1);
            default: reload = STEP_CNT_W'(STEP_TICKS - 1);
        endcase
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
            step <= 1'b0;
        end else if (speed_sel == 2'b00) begin
            // traffic stopped, counter frozen
            step <= 1'b0;
        end else if (count == '0) begin
            count <= reload;
            step <= 1'b1;
        end else begin
            count <= count - 1'b1;
            step <= 1'b0;
        end
    end

endmodule

/* hw/traffic_lanes.sv */
// traffic_lanes: rotating lane patterns, sweep cell index, cell colour and frog collision
`timescale 1ns/1ps

module traffic_lanes (
    input  logic                 fastclock,
    input  logic                 resetn,
    input  logic                 step,
    input  logic                 sweep_next,
    input  frogger_pkg::col_t    frog_col,
    input  frogger_pkg::row_t    frog_row,
    output frogger_pkg::col_t    sweep_col,
    output frogger_pkg::row_t    sweep_row,
    output frogger_pkg::colour_t sweep_colour,
    output logic                 hit
);
    import frogger_pkg::*;

    lane_bits_t lane_q [LANE_COUNT];
    lane_t      sweep_lane;
    lane_t      frog_lane;
    logic       frog_in_lane;
    col_t       sweep_bit;
    col_t       frog_bit;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            for (int k = 0; k < LANE_COUNT; k++) begin
                lane_q[k] <= LANE_SEED[k];
            end
        end else if (step) begin
            for (int k = 0; k < LANE_COUNT; k++) begin
                lane_q[k] <= {lane_q[k][14:0], lane_q[k][15]};
            end
        end
    end

    // sweep walks columns first, then lanes
    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            sweep_col <= '0;
            sweep_lane <= '0;
        end else if (sweep_next) begin
            sweep_col <= sweep_col + 1'b1;
            if (sweep_col == col_t'(GRID_COLS - 1)) begin
                sweep_lane <= sweep_lane + 1'b1;
            end
        end
    end

    assign sweep_row = row_t'(sweep_lane) + row_t'(FIRST_LANE_ROW);

    // leftmost column reads the msb
    assign sweep_bit = col_t'(GRID_COLS - 1) - sweep_col;
    assign frog_bit = col_t'(GRID_COLS - 1) - frog_col;

    always_comb begin
        if (frog_col == sweep_col && frog_row == sweep_row) begin
            sweep_colour = COLOUR_FROG;
        end else if (lane_q[sweep_lane][sweep_bit]) begin
            sweep_colour = COLOUR_CAR;
        end else begin
            sweep_colour = COLOUR_ROAD;
        end
    end

    assign frog_in_lane = (frog_row >= row_t'(FIRST_LANE_ROW)) &&
                          (frog_row < row_t'(FIRST_LANE_ROW + LANE_COUNT));
    assign frog_lane = lane_t'(frog_row - row_t'(FIRST_LANE_ROW));
    assign hit = frog_in_lane && lane_q[frog_lane][frog_bit];

endmodule

/* hw/frog_position.sv */
// frog_position: frog grid position with edge clamping, respawn request and win level
`timescale 1ns/1ps

module frog_position (
    input  logic              fastclock,
    input  logic              resetn,
    input  logic              up,
    input  logic              down,
    input  logic              left,
    input  logic              right,
    input  logic              apply_move,
    input  logic              hit,
    output frogger_pkg::col_t frog_col,
    output frogger_pkg::row_t frog_row,
    output logic              respawn_req,
    output logic              win
);
    import frogger_pkg::*;

    col_t next_col;
    row_t next_row;

    // opposite buttons cancel, moves off the grid are dropped
    always_comb begin
        next_col = frog_col;
        next_row = frog_row;
        if (up && !down && frog_row != '0) begin
            next_row = frog_row - 1'b1;
        end
        if (down && !up && frog_row != row_t'(GRID_ROWS - 1)) begin
            next_row = frog_row + 1'b1;
        end
        if (left && !right && frog_col != '0) begin
            next_col = frog_col - 1'b1;
        end
        if (right && !left && frog_col != col_t'(GRID_COLS - 1)) begin
            next_col = frog_col + 1'b1;
        end
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            frog_col <= FROG_START_COL;
            frog_row <= FROG_START_ROW;
            respawn_req <= 1'b0;
        end else if (hit) begin
            // run over, back to the start cell
            frog_col <= FROG_START_COL;
            frog_row <= FROG_START_ROW;
            respawn_req <= 1'b1;
        end else if (apply_move) begin
            frog_col <= next_col;
            frog_row <= next_row;
            respawn_req <= 1'b0;
        end
    end

    assign win = (frog_row == WIN_ROW);

endmodule

/* hw/cell_painter.sv */
// cell_painter: cell origin and colour latch with 8 by 8 pixel block stepper
`timescale 1ns/1ps

module cell_painter (
    input  logic                 fastclock,
    input  logic                 resetn,
    input  logic                 load_frog,
    input  logic                 load_sweep,
    input  logic                 erase,
    input  frogger_pkg::col_t    frog_col,
    input  frogger_pkg::col_t    sweep_col,
    input  frogger_pkg::row_t    frog_row,
    input  frogger_pkg::row_t    sweep_row,
    input  frogger_pkg::colour_t sweep_colour,
    output frogger_pkg::px_x_t   plot_x,
    output frogger_pkg::px_y_t   plot_y,
    output frogger_pkg::colour_t plot_colour,
    output logic                 block_done
);
    import frogger_pkg::*;

    px_x_t origin_x;
    px_y_t origin_y;
    logic [2*SIDE_BITS-1:0] pixel_cnt;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            origin_x <= '0;
            origin_y <= '0;
            plot_colour <= COLOUR_ROAD;
        end else if (load_frog) begin
            origin_x <= px_x_t'(frog_col) * px_x_t'(CELL_PITCH_X);
            origin_y <= px_y_t'(frog_row) * px_y_t'(CELL_PITCH_Y);
            plot_colour <= erase ? COLOUR_ROAD : COLOUR_FROG;
        end else if (load_sweep) begin
            origin_x <= px_x_t'(sweep_col) * px_x_t'(CELL_PITCH_X);
            origin_y <= px_y_t'(sweep_row) * px_y_t'(CELL_PITCH_Y);
            plot_colour <= sweep_colour;
        end
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            pixel_cnt <= '0;
        end else if (load_frog || load_sweep) begin
            pixel_cnt <= '0;
        end else begin
            pixel_cnt <= pixel_cnt + 1'b1;
        end
    end

    // low half steps x, high half steps y
    assign plot_x = origin_x + px_x_t'(pixel_cnt[SIDE_BITS-1:0]);
    assign plot_y = origin_y + px_y_t'(pixel_cnt[2*SIDE_BITS-1:SIDE_BITS]);
    assign block_done = (pixel_cnt == (2*SIDE_BITS)'(BLOCK_PIXELS - 1));

endmodule

/* hw/draw_sequencer.sv */
// draw_sequencer: FSM interleaving frog erase, move and redraw with the traffic sweep
`timescale 1ns/1ps

module draw_sequencer (
    input  logic fastclock,
    input  logic resetn,
    input  logic up,
    input  logic down,
    input  logic left,
    input  logic right,
    input  logic respawn_req,
    input  logic block_done,
    output logic load_frog,
    output logic load_sweep,
    output logic erase,
    output logic apply_move,
    output logic sweep_next,
    output logic plot
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ERASE_LOAD,
        S_ERASE_PAINT,
        S_UPDATE,
        S_DRAW_LOAD,
        S_DRAW_PAINT,
        S_RELEASE_WAIT,
        S_SWEEP_LOAD,
        S_SWEEP_PAINT
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   any_button;

    assign any_button = up || down || left || right;

    always_comb begin
        state_nxt = state;
        case (state)
            // cell boundary, frog work wins over the sweep
            S_IDLE: begin
                if (any_button || respawn_req) begin
                    state_nxt = S_ERASE_LOAD;
                end else begin
                    state_nxt = S_SWEEP_LOAD;
                end
            end
            S_ERASE_LOAD: state_nxt = S_ERASE_PAINT;
            S_ERASE_PAINT: begin
                if (block_done) begin
                    state_nxt = S_UPDATE;
                end
            end
            S_UPDATE: state_nxt = S_DRAW_LOAD;
            S_DRAW_LOAD: state_nxt = S_DRAW_PAINT;
            S_DRAW_PAINT: begin
                if (block_done) begin
                    state_nxt = S_RELEASE_WAIT;
                end
            end
            // one move per press
            S_RELEASE_WAIT: begin
                if (!any_button) begin
                    state_nxt = S_IDLE;
                end
            end
            S_SWEEP_LOAD: state_nxt = S_SWEEP_PAINT;
            S_SWEEP_PAINT: begin
                if (block_done) begin
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign load_frog = (state == S_ERASE_LOAD) || (state == S_DRAW_LOAD);
    assign erase = (state == S_ERASE_LOAD);
    assign load_sweep = (state == S_SWEEP_LOAD);
    assign apply_move = (state == S_UPDATE);
    // painter has the colour latched, so the index can move on the last pixel
    assign sweep_next = (state == S_SWEEP_PAINT) && block_done;
    assign plot = (state == S_ERASE_PAINT) || (state == S_DRAW_PAINT) ||
                  (state == S_SWEEP_PAINT);

endmodule

/* hw/frogger_top.sv */
// frogger_top: frog crossing game top level driving the 160x120 plot port
`timescale 1ns/1ps

module frogger_top #(
    parameter int unsigned STEP_TICKS = frogger_pkg::DEFAULT_STEP_TICKS
) (
    input  logic                 fastclock,
    input  logic                 resetn,
    input  logic                 up,
    input  logic                 down,
    input  logic                 left,
    input  logic                 right,
    input  frogger_pkg::speed_t  speed_sel,
    output frogger_pkg::px_x_t   plot_x,
    output frogger_pkg::px_y_t   plot_y,
    output frogger_pkg::colour_t plot_colour,
    output logic                 plot,
    output logic                 win
);
    import frogger_pkg::*;

    logic    step;
    logic    hit;
    logic    respawn_req;
    logic    block_done;
    logic    load_frog;
    logic    load_sweep;
    logic    erase;
    logic    apply_move;
    logic    sweep_next;
    col_t    frog_col;
    row_t    frog_row;
    col_t    sweep_col;
    row_t    sweep_row;
    colour_t sweep_colour;

    lane_tick_timer #(
        .STEP_TICKS(STEP_TICKS)
    ) lane_tick_timer_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .speed_sel(speed_sel),
        .step(step)
    );

    traffic_lanes traffic_lanes_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .step(step),
        .sweep_next(sweep_next),
        .frog_col(frog_col),
        .frog_row(frog_row),
        .sweep_col(sweep_col),
        .sweep_row(sweep_row),
        .sweep_colour(sweep_colour),
        .hit(hit)
    );

    frog_position frog_position_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .up(up),
        .down(down),
        .left(left),
        .right(right),
        .apply_move(apply_move),
        .hit(hit),
        .frog_col(frog_col),
        .frog_row(frog_row),
        .respawn_req(respawn_req),
        .win(win)
    );

    cell_painter cell_painter_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .load_frog(load_frog),
        .load_sweep(load_sweep),
        .erase(erase),
        .frog_col(frog_col),
        .sweep_col(sweep_col),
        .frog_row(frog_row),
        .sweep_row(sweep_row),
        .sweep_colour(sweep_colour),
        .plot_x(plot_x),
        .plot_y(plot_y),
        .plot_colour(plot_colour),
        .block_done(block_done)
    );

    draw_sequencer draw_sequencer_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .up(up),
        .down(down),
        .left(left),
        .right(right),
        .respawn_req(respawn_req),
        .block_done(block_done),
        .load_frog(load_frog),
        .load_sweep(load_sweep),
        .erase(erase),
        .apply_move(apply_move),
        .sweep_next(sweep_next),
        .plot(plot)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// tb_clock_gen: 4 ns testbench clock and 16-cycle active-low reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD = 4ns,
    parameter int      RESET_CYCLES = 16
) (
    output logic fastclock,
    output logic resetn
);

    initial begin
        fastclock = 1'b0;
        forever #(PERIOD / 2) fastclock = ~fastclock;
    end

    // release just after an edge so the first active edge sees a clean reset
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge fastclock);
        #1 resetn = 1'b1;
    end

endmodule

/* testbench/frogger_checker.sv */
// frogger_checker: concurrent assertions on plot during reset, win level and respawn
`timescale 1ns/1ps

module frogger_checker (
    input logic              fastclock,
    input logic              resetn,
    input logic              plot,
    input logic              win,
    input frogger_pkg::row_t frog_row,
    input logic              hit,
    input logic              respawn_req
);
    import frogger_pkg::*;

    // nothing reaches the plot port while reset is held
    plot_low_in_reset: assert property (
        @(posedge fastclock) !resetn |-> !plot
    ) else $error("plot high while resetn is low");

    win_tracks_row: assert property (
        @(posedge fastclock) disable iff (!resetn)
        win == (frog_row == WIN_ROW)
    ) else $error("win does not match frog row %0d", frog_row);

    // frog sits on the start row once respawned
    no_hit_after_respawn: assert property (
        @(posedge fastclock) disable iff (!resetn)
        $rose(respawn_req) |-> !hit
    ) else $error("hit high in the cycle after a respawn");

endmodule

/* testbench/tb_frogger.sv */
// tb_frogger: testbench top with stimulus reader, plot monitor, lane and frog model, report
`timescale 1ns/1ps

module tb_frogger;
    import frogger_pkg::*;

    localparam int STIM_WORDS = 256;
    localparam int CELL_CYCLES = BLOCK_PIXELS + 2;

    logic        fastclock;
    logic        resetn;
    logic        up;
    logic        down;
    logic        left;
    logic        right;
    speed_t      speed_sel;
    px_x_t       plot_x;
    px_y_t       plot_y;
    colour_t     plot_colour;
    logic        plot;
    logic        win;

    logic [7:0]  stim [STIM_WORDS];
    logic [17:0] blocks [$];
    lane_bits_t  lane_m [LANE_COUNT];
    col_t        frog_c;
    row_t        frog_r;
    col_t        seen_c;
    row_t        seen_r;
    col_t        sweep_c;
    lane_t       sweep_l;
    px_x_t       blk_x;
    px_y_t       blk_y;
    colour_t     blk_c;
    int          pix_n = 0;
    int          errors = 0;
    int          test_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit = 1_000_000;
    logic [31:0] rand_state = 32'd18;

    tb_clock_gen clock_gen_i (
        .fastclock(fastclock),
        .resetn(resetn)
    );

    frogger_top #(
        .STEP_TICKS(200)
    ) frogger_top_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .up(up),
        .down(down),
        .left(left),
        .right(right),
        .speed_sel(speed_sel),
        .plot_x(plot_x),
        .plot_y(plot_y),
        .plot_colour(plot_colour),
        .plot(plot),
        .win(win)
    );

    bind frogger_top frogger_checker frogger_checker_i (
        .fastclock(fastclock),
        .resetn(resetn),
        .plot(plot),
        .win(win),
        .frog_row(frog_row),
        .hit(hit),
        .respawn_req(respawn_req)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // groups 64 plot pixels into one block and checks its shape
    always @(posedge fastclock) begin
        if (resetn && plot) begin
            if (pix_n == 0) begin
                blk_x = plot_x;
                blk_y = plot_y;
                blk_c = plot_colour;
                if (plot_x % CELL_PITCH_X != 0 || plot_x / CELL_PITCH_X >= GRID_COLS ||
                    plot_y % CELL_PITCH_Y != 0 || plot_y / CELL_PITCH_Y >= GRID_ROWS) begin
                    $display("** Error: plot_x = %h, plot_y = %h is not a cell origin",
                             plot_x, plot_y);
                    errors++;
                end
            end
            if (plot_x !== blk_x + px_x_t'(pix_n % BLOCK_SIDE) ||
                plot_y !== blk_y + px_y_t'(pix_n / BLOCK_SIDE)) begin
                $display("** Error: plot_x = %h, plot_y = %h, expected %h, %h", plot_x, plot_y,
                         blk_x + px_x_t'(pix_n % BLOCK_SIDE), blk_y + px_y_t'(pix_n / BLOCK_SIDE));
                errors++;
            end
            if (plot_colour !== blk_c) begin
                $display("** Error: plot_colour = %h, expected %h", plot_colour, blk_c);
                errors++;
            end
            if (pix_n == BLOCK_PIXELS - 1) begin
                blocks.push_back({blk_x, blk_y, blk_c});
                pix_n = 0;
            end else begin
                pix_n++;
            end
        end else if (resetn && pix_n != 0) begin
            $display("plot dropped low after %0d pixels of a block", pix_n);
            errors++;
            pix_n = 0;
        end
    end

    always @(posedge fastclock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped painting blocks", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // returns just after the edge that samples the last pixel of a block
    task automatic next_block(output px_x_t x, output px_y_t y, output colour_t c);
        logic [17:0] b;
        while (blocks.size() == 0) begin
            @(posedge fastclock);
            #1;
        end
        b = blocks.pop_front();
        {x, y, c} = b;
    endtask

    task automatic sweep_block(input bit check_colour, output colour_t c);
        px_x_t   x;
        px_y_t   y;
        colour_t exp_c;
        row_t    row;
        next_block(x, y, c);
        row = row_t'(sweep_l) + 3'd1;
        if (x !== px_x_t'(sweep_c * CELL_PITCH_X) || y !== px_y_t'(row * CELL_PITCH_Y)) begin
            $display("** Error: sweep plot_x = %h, plot_y = %h, expected %h, %h", x, y,
                     px_x_t'(sweep_c * CELL_PITCH_X), px_y_t'(row * CELL_PITCH_Y));
            errors++;
        end
        if (sweep_c == frog_c && row == frog_r) begin
            exp_c = COLOUR_FROG;
        end else if (lane_m[sweep_l][15 - sweep_c]) begin
            exp_c = COLOUR_CAR;
        end else begin
            exp_c = COLOUR_ROAD;
        end
        if (check_colour && c !== exp_c) begin
            $display("** Error: sweep plot_colour = %h, expected %h", c, exp_c);
            errors++;
        end
        if (sweep_c == col_t'(GRID_COLS - 1)) begin
            sweep_l++;
        end
        sweep_c++;
    endtask

    task automatic frog_block(input col_t col, input row_t row, input colour_t exp_c);
        px_x_t   x;
        px_y_t   y;
        colour_t c;
        next_block(x, y, c);
        if (x !== px_x_t'(col * CELL_PITCH_X) || y !== px_y_t'(row * CELL_PITCH_Y)) begin
            $display("** Error: frog plot_x = %h, plot_y = %h, expected %h, %h", x, y,
                     px_x_t'(col * CELL_PITCH_X), px_y_t'(row * CELL_PITCH_Y));
            errors++;
        end
        if (c !== exp_c) begin
            $display("** Error: frog plot_colour = %h, expected %h", c, exp_c);
            errors++;
        end
        if (exp_c == COLOUR_FROG) begin
            seen_c = col_t'(x / CELL_PITCH_X);
            seen_r = row_t'(y / CELL_PITCH_Y);
        end
    endtask

    // dirs is up, down, left, right; traffic must be stopped
    task automatic move_frog(input logic [3:0] dirs);
        colour_t c;
        int      tc;
        int      tr;
        col_t    nc;
        row_t    nr;
        sweep_block(1'b1, c);
        {up, down, left, right} = dirs;
        tc = int'(frog_c) + int'(dirs[0]) - int'(dirs[1]);
        tr = int'(frog_r) + int'(dirs[2]) - int'(dirs[3]);
        nc = (tc >= 0 && tc < GRID_COLS) ? col_t'(tc) : frog_c;
        nr = (tr >= 0 && tr < GRID_ROWS) ? row_t'(tr) : frog_r;
        frog_block(frog_c, frog_r, COLOUR_ROAD);
        frog_block(nc, nr, COLOUR_FROG);
        {up, down, left, right} = 4'b0000;
        frog_c = nc;
        frog_r = nr;
        if (nr >= 1 && nr <= LANE_COUNT && lane_m[nr - 1][15 - nc]) begin
            frog_c = FROG_START_COL;
            frog_r = FROG_START_ROW;
            frog_block(frog_c, frog_r, COLOUR_ROAD);
            frog_block(frog_c, frog_r, COLOUR_FROG);
        end
        if (win !== (frog_r == 0)) begin
            $display("** Error: win = %h, expected %h", win, frog_r == 0);
            errors++;
        end
    endtask

    // one full sweep after traffic stops, then adopt the common rotation
    task automatic lane_rotation();
        lane_bits_t obs [LANE_COUNT];
        lane_bits_t rot [LANE_COUNT];
        colour_t    c;
        col_t       col;
        lane_t      lane;
        int         found;
        logic       same;
        sweep_block(1'b0, c);
        for (int i = 0; i < GRID_COLS * LANE_COUNT; i++) begin
            col = sweep_c;
            lane = sweep_l;
            sweep_block(1'b0, c);
            obs[lane][15 - col] = (c == COLOUR_CAR);
            if (c != COLOUR_CAR && c != COLOUR_ROAD) begin
                $display("** Error: lane plot_colour = %h, expected %h or %h", c, COLOUR_CAR,
                         COLOUR_ROAD);
                errors++;
            end
        end
        for (int k = 0; k < LANE_COUNT; k++) begin
            rot[k] = LANE_SEED[k];
        end
        found = -1;
        for (int r = 0; r < GRID_COLS; r++) begin
            same = 1'b1;
            for (int k = 0; k < LANE_COUNT; k++) begin
                if (rot[k] != obs[k]) begin
                    same = 1'b0;
                end
                rot[k] = {rot[k][14:0], rot[k][15]};
            end
            if (same && found < 0) begin
                found = r;
            end
        end
        if (found < 0) begin
            $display("observed lanes are not one common left rotation of the seeds");
            errors++;
        end else if (found == 0) begin
            $display("observed lanes still equal the seeds, traffic did not move");
            errors++;
        end
        for (int k = 0; k < LANE_COUNT; k++) begin
            lane_m[k] = obs[k];
        end
    endtask

    task automatic end_test(input int n);
        tests_run++;
        if (errors != test_base) begin
            tests_failed++;
        end
        $display("test %0d %s, %0d errors", n, (errors == test_base) ? "ok" : "failed",
                 errors - test_base);
        test_base = errors;
    endtask

    initial begin
        int         pc;
        int         sweeps;
        int         moves;
        logic [7:0] cmd;
        logic [7:0] arg;
        logic [7:0] ecol;
        logic [7:0] erow;
        colour_t    c;
        up = 1'b0;
        down = 1'b0;
        left = 1'b0;
        right = 1'b0;
        speed_sel = 2'b00;
        for (int k = 0; k < LANE_COUNT; k++) begin
            lane_m[k] = LANE_SEED[k];
        end
        frog_c = FROG_START_COL;
        frog_r = FROG_START_ROW;
        seen_c = FROG_START_COL;
        seen_r = FROG_START_ROW;
        sweep_c = '0;
        sweep_l = '0;
        $readmemh("testbench/frogger_stimulus.txt", stim);

        // timeout sized from the sweep and move counts in the stimulus
        sweeps = 0;
        moves = 0;
        for (pc = 0; pc < STIM_WORDS && !$isunknown(stim[pc]) && stim[pc] != 0; pc += 4) begin
            case (stim[pc])
                8'h01, 8'h04: sweeps += stim[pc + 1];
                8'h05: sweeps += 2;
                8'h02: moves += 1;
                8'h07: moves += stim[pc + 1];
                default: ;
            endcase
        end
        cycle_limit = (sweeps * GRID_COLS * LANE_COUNT + moves * 5) * CELL_CYCLES + 2000;

        wait (resetn === 1'b1);
        for (pc = 0; pc < STIM_WORDS && !$isunknown(stim[pc]) && stim[pc] != 0; pc += 4) begin
            cmd = stim[pc];
            arg = stim[pc + 1];
            ecol = stim[pc + 2];
            erow = stim[pc + 3];
            case (cmd)
                8'h01: repeat (arg * GRID_COLS * LANE_COUNT) sweep_block(1'b1, c);
                8'h02: move_frog(arg[3:0]);
                8'h03: speed_sel = speed_t'(arg);
                8'h04: repeat (arg * GRID_COLS * LANE_COUNT) sweep_block(1'b0, c);
                8'h05: lane_rotation();
                8'h06: end_test(arg);
                8'h07: begin
                    repeat (arg) begin
                        rand_state = lcg_next(rand_state);
                        move_frog(4'b0001 << rand_state[17:16]);
                    end
                end
                default: begin
                    $display("unknown stimulus command %h at word %0d", cmd, pc);
                    errors++;
                end
            endcase
            if (ecol != 8'hff && (seen_c !== ecol[3:0] || seen_r !== erow[2:0])) begin
                $display("** Error: drawn frog col = %h, row = %h, expected %h, %h",
                         seen_c, seen_r, ecol[3:0], erow[2:0]);
                errors++;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* testbench/frogger_stimulus.txt */
// columns: cmd arg col row, expected drawn frog cell in col row, ff skips that check
// cmd 01 check sweeps, 02 move (8 up 4 down 2 left 1 right), 03 speed, 04 run sweeps,
// cmd 05 lane rotation sweep, 06 end of test, 07 random moves, 00 end of stimulus
01 01 08 06
06 01 ff ff
01 01 08 06
06 02 ff ff
02 08 08 05
02 04 08 06
02 04 08 06
06 03 ff ff
02 08 08 05
02 08 08 06
01 01 08 06
06 04 ff ff
02 01 09 06
02 08 09 05
02 08 09 04
02 08 09 03
02 08 09 02
02 08 09 01
02 08 09 00
02 04 09 01
02 04 09 02
02 04 09 03
02 04 09 04
02 04 09 05
06 05 ff ff
03 03 ff ff
04 02 ff ff
03 00 ff ff
05 00 ff ff
07 0c ff ff
01 01 ff ff
06 06 ff ff
00 00 ff ff

/* files.f */
hw/frogger_pkg.sv
hw/lane_tick_timer.sv
hw/traffic_lanes.sv
hw/frog_position.sv
hw/cell_painter.sv
hw/draw_sequencer.sv
hw/frogger_top.sv
testbench/tb_clock_gen.sv
testbench/frogger_checker.sv
testbench/tb_frogger.sv

/* Bender.yml */
package:
  name: frogger

sources:
  - hw/frogger_pkg.sv
  - hw/lane_tick_timer.sv
  - hw/traffic_lanes.sv
  - hw/frog_position.sv
  - hw/cell_painter.sv
  - hw/draw_sequencer.sv
  - hw/frogger_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/frogger_checker.sv
      - testbench/tb_frogger.sv
